/* Bender.yml */
package:
  name: vp8_quant

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vp8_quant_pkg.sv
      - verilog/quant_matrix_store.sv
      - verilog/matrix_port_arbiter.sv
      - verilog/matrix_expander.sv
      - verilog/block_quantizer.sv
      - verilog/zigzag_collector.sv
      - verilog/vp8_quant_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/vp8_quant_tb.sv

/* bench/quant_ref_model.svh */
/* Reference model for the VP8 block quantizer
   Expected matrix entry expansion and per-coefficient quantization */
`ifndef QUANT_REF_MODEL_SVH
`define QUANT_REF_MODEL_SVH

// Sharpen weights by raster position
localparam int sharpen_table [16] = '{0, 30, 60, 90, 30, 60, 90, 90,
                                      60, 90, 90, 90, 90, 90, 90, 90};

// Raster position of each zigzag slot
localparam int zigzag_order [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

function automatic int bias_byte(input mat_type_t t, input int idx);
    case (t)
        mat_luma_ac: return (idx == 0) ? 96 : 110;
        mat_luma_dc: return (idx == 0) ? 96 : 108;
        default:     return (idx == 0) ? 110 : 115;
    endcase
endfunction

function automatic mat_entry_t expand_entry(input mat_type_t t, input int idx, input int q);
    mat_entry_t e;
    longint     bias;
    longint     iq;
    bias      = longint'(bias_byte(t, idx)) << 9;
    iq        = (longint'(1) << 17) / q;
    e.q       = qstep_t'(q);
    e.iq      = qstep_t'(iq);
    e.bias    = qbias_t'(bias);
    e.zthresh = qbias_t'(((longint'(1) << 17) - 1 - bias) / iq);
    e.sharpen = (t == mat_luma_ac) ? qstep_t'((sharpen_table[idx] * q) >> 11) : '0;
    return e;
endfunction

function automatic void quantize_coeff(input coeff_t x, input mat_entry_t e,
                                       output coeff_t level, output coeff_t recon);
    longint mag;
    longint coeff;
    longint lvl;
    mag   = (x < 0) ? -longint'(x) : longint'(x);
    coeff = mag + longint'(e.sharpen);
    lvl   = (coeff * longint'(e.iq) + longint'(e.bias)) >> 17;
    if (lvl > 2047) lvl = 2047;
    if (coeff > longint'(e.zthresh)) begin
        if (x < 0) lvl = -lvl;
        level = coeff_t'(lvl);
        // int16 store, keeps the low 16 bits
        recon = coeff_t'(lvl * longint'(e.q));
    end else begin
        level = '0;
        recon = '0;
    end
endfunction

`endif

/* bench/vp8_quant_tb.sv */
/* VP8 block quantizer testbench
   Loads the matrix, runs random, small, clamping and contended blocks against a model */
`timescale 1ns/1ps

module vp8_quant_tb
    import vp8_quant_pkg::*;
();

    localparam int n_blocks       = 9;
    localparam int n_writes       = 65;
    localparam int timeout_cycles = n_blocks * 200 + n_writes * 60 + 32;

    logic         clk;
    logic         rst_n;
    logic         cfg_we_i;
    mat_type_t    cfg_type_i;
    mat_idx_t     cfg_idx_i;
    qstep_t       cfg_q_i;
    logic         cfg_busy_o;
    logic         start_i;
    mat_type_t    blk_type_i;
    coeff_block_t coeffs_i;
    coeff_block_t levels_o;
    coeff_block_t recon_o;
    logic         nz_o;
    logic         done_o;

    integer     seed;
    int         mismatch_cnt;
    int         proto_cnt;
    int         start_cnt;
    int         done_cnt;
    int         overlap_cnt;
    int         cycle_cnt;
    int         pending_addr;
    mat_entry_t model_mat [48];
    coeff_t     exp_levels [16];
    coeff_t     exp_recon [16];
    logic       exp_nz;

    `include "quant_ref_model.svh"

    vp8_quant_top dut_i (
        .clk, .rst_n, .cfg_we_i, .cfg_type_i, .cfg_idx_i, .cfg_q_i, .cfg_busy_o,
        .start_i, .blk_type_i, .coeffs_i, .levels_o, .recon_o, .nz_o, .done_o
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Protocol checks and monitors
    // ------------------------------------------------------------------
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
        else begin
            proto_cnt++;
            $display("done_o stayed high for more than one cycle");
        end

    busy_follows_write: assert property (@(posedge clk) disable iff (!rst_n)
                                         $rose(cfg_busy_o) |-> $past(cfg_we_i))
        else begin
            proto_cnt++;
            $display("cfg_busy_o rose without a configuration write");
        end

    always @(posedge clk) begin
        if (done_o) done_cnt++;
        // Write and read requests in the same cycle
        if (dut_i.wr_req && dut_i.rd_req) overlap_cnt++;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run exceeded %0d cycles", timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string test, input string what,
                               input longint expected, input longint actual);
        assert (expected == actual) else begin
            mismatch_cnt++;
            $display("mismatch %s %s: expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    function automatic coeff_block_t random_block(input int span);
        coeff_block_t blk;
        for (int k = 0; k < 16; k++) begin
            blk[k] = coeff_t'($random(seed) % span);
        end
        return blk;
    endfunction

    task automatic issue_write(input mat_type_t t, input int idx, input int q);
        @(negedge clk);
        cfg_we_i   = 1'b1;
        cfg_type_i = t;
        cfg_idx_i  = mat_idx_t'(idx);
        cfg_q_i    = qstep_t'(q);
        @(negedge clk);
        cfg_we_i     = 1'b0;
        pending_addr = int'(t) * 16 + idx;
        model_mat[pending_addr] = expand_entry(t, idx, q);
        assert (cfg_busy_o) else begin
            proto_cnt++;
            $display("cfg_busy_o did not rise after a configuration write");
        end
    endtask

    task automatic complete_write(input string test);
        mat_entry_t act;
        mat_entry_t exp;
        while (cfg_busy_o) @(negedge clk);
        act = dut_i.u_store.mem[pending_addr];
        exp = model_mat[pending_addr];
        check_value(test, $sformatf("entry %0d q", pending_addr), exp.q, act.q);
        check_value(test, $sformatf("entry %0d iq", pending_addr), exp.iq, act.iq);
        check_value(test, $sformatf("entry %0d bias", pending_addr), exp.bias, act.bias);
        check_value(test, $sformatf("entry %0d zthresh", pending_addr), exp.zthresh, act.zthresh);
        check_value(test, $sformatf("entry %0d sharpen", pending_addr), exp.sharpen, act.sharpen);
    endtask

    task automatic write_entry(input mat_type_t t, input int idx, input int q, input string test);
        issue_write(t, idx, q);
        complete_write(test);
    endtask

    task automatic start_block(input mat_type_t t, input coeff_block_t blk);
        coeff_t lv [16];
        coeff_t rc;
        exp_nz = 1'b0;
        for (int k = 0; k < 16; k++) begin
            quantize_coeff(blk[k], model_mat[int'(t) * 16 + k], lv[k], rc);
            exp_recon[k] = rc;
            if (lv[k] != 0) exp_nz = 1'b1;
        end
        for (int k = 0; k < 16; k++) begin
            exp_levels[k] = lv[zigzag_order[k]];
        end
        @(negedge clk);
        start_i    = 1'b1;
        blk_type_i = t;
        coeffs_i   = blk;
        start_cnt++;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic finish_block(input string test);
        while (!done_o) @(negedge clk);
        for (int k = 0; k < 16; k++) begin
            check_value(test, $sformatf("level[%0d]", k), exp_levels[k], levels_o[k]);
            check_value(test, $sformatf("recon[%0d]", k), exp_recon[k], recon_o[k]);
        end
        check_value(test, "nz", exp_nz, nz_o);
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        coeff_block_t blk;
        seed         = 32'h7ddc;
        mismatch_cnt = 0;
        proto_cnt    = 0;
        start_cnt    = 0;
        done_cnt     = 0;
        overlap_cnt  = 0;
        rst_n        = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_type_i   = mat_luma_ac;
        cfg_idx_i    = '0;
        cfg_q_i      = '0;
        start_i      = 1'b0;
        blk_type_i   = mat_luma_ac;
        coeffs_i     = '0;

        repeat (8) @(negedge clk);
        assert (!done_o && !cfg_busy_o) else begin
            proto_cnt++;
            $display("done_o or cfg_busy_o high during reset");
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!done_o && !cfg_busy_o) else begin
                proto_cnt++;
                $display("done_o or cfg_busy_o high before any stimulus");
            end
        end

        // Full matrix load
        for (int t = 0; t < 3; t++) begin
            for (int i = 0; i < 16; i++) begin
                write_entry(mat_type_t'(t), i, 8 + ({$random(seed)} % 120), "load");
            end
        end

        for (int t = 0; t < 3; t++) begin
            repeat (2) begin
                start_block(mat_type_t'(t), random_block(1024));
                finish_block("random");
            end
        end

        // All coefficients under zthresh
        start_block(mat_chroma, random_block(4));
        finish_block("small");
        check_value("small", "nz low", 0, nz_o);

        // Small q so full-scale input saturates
        for (int i = 0; i < 16; i++) begin
            write_entry(mat_luma_dc, i, 8 + (i % 8), "clamp_cfg");
        end
        for (int k = 0; k < 16; k++) begin
            blk[k] = (k % 2 == 1) ? -16'sd32767 : 16'sd32767;
        end
        blk[15] = -16'sd32768;
        start_block(mat_luma_dc, blk);
        finish_block("clamp");
        for (int k = 0; k < 16; k++) begin
            assert (levels_o[k] == 2047 || levels_o[k] == -2047) else begin
                mismatch_cnt++;
                $display("mismatch clamp level[%0d]: expected +-2047, actual %0d", k, levels_o[k]);
            end
        end

        // Write lands while the block reads are running
        issue_write(mat_chroma, 5, 8 + ({$random(seed)} % 120));
        repeat (28) @(negedge clk);
        start_block(mat_luma_ac, random_block(1024));
        finish_block("contention");
        complete_write("contention");
        assert (overlap_cnt > 0) else begin
            proto_cnt++;
            $display("configuration write did not overlap the block reads");
        end
        repeat (4) @(negedge clk);
        check_value("contention", "done pulses", start_cnt, done_cnt);

        $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, proto_cnt);
        if (mismatch_cnt == 0 && proto_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog/block_quantizer.sv */
/* Block quantizer
   Reads one matrix entry per coefficient and runs a three-stage quantize pipeline */
`timescale 1ns/1ps
`include "vp8_quant_defs.svh"

module block_quantizer
    import vp8_quant_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_i,
    input  mat_type_t    blk_type_i,
    input  coeff_block_t coeffs_i,
    output logic         rd_req_o,
    output mat_addr_t    rd_addr_o,
    input  logic         rd_gnt_i,
    input  logic         rd_valid_i,
    input  mat_entry_t   rdata_i,
    output logic         res_valid_o,
    output qres_t        res_o
);

    localparam mat_idx_t last_idx = mat_idx_t'(`QB_NCOEF - 1);

    coeff_block_t       blk_q;
    mat_type_t          type_q;
    logic               active_q;
    mat_idx_t           rd_idx_q;
    mat_idx_t           tag_q;
    coeff_t             s1_in;
    logic               s1_sign;
    logic [15:0]        s1_abs;
    logic [16:0]        s1_coeff;
    logic [33:0]        s1_sum;
    logic               s1_pass;
    logic               s2_valid_q;
    mat_idx_t           s2_idx_q;
    logic               s2_sign_q;
    logic               s2_pass_q;
    logic [16:0]        s2_level_q;
    qstep_t             s2_q_q;
    logic [10:0]        level_mag;
    coeff_t             level_sgn;
    logic signed [31:0] recon_full;

    // ------------------------------------------------------------------
    // Read sequencing, one index per grant
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            rd_idx_q <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            rd_idx_q <= '0;
        end else if (active_q && rd_gnt_i) begin
            rd_idx_q <= rd_idx_q + 4'd1;
            if (rd_idx_q == last_idx) active_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            blk_q  <= coeffs_i;
            type_q <= blk_type_i;
        end
        // Entry returns next cycle, remember whose it is
        if (rd_gnt_i) tag_q <= rd_idx_q;
    end

    assign rd_req_o  = active_q;
    assign rd_addr_o = '{mtype: type_q, idx: rd_idx_q};

    // ------------------------------------------------------------------
    // Stage 1, entry arrives
    // ------------------------------------------------------------------
    always_comb begin
        s1_in    = blk_q[tag_q];
        s1_sign  = s1_in[15];
        s1_abs   = s1_sign ? 16'(-s1_in) : 16'(s1_in);
        s1_coeff = 17'(s1_abs) + 17'(rdata_i.sharpen);
        s1_sum   = {17'd0, s1_coeff} * {18'd0, rdata_i.iq} + {2'd0, rdata_i.bias};
        s1_pass  = {15'd0, s1_coeff} > rdata_i.zthresh;
    end

    // Stage 2, scaled level registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid_q <= 1'b0;
        end else begin
            s2_valid_q <= rd_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid_i) begin
            s2_idx_q   <= tag_q;
            s2_sign_q  <= s1_sign;
            s2_pass_q  <= s1_pass;
            s2_level_q <= 17'(s1_sum >> `QB_SHIFT);
            s2_q_q     <= rdata_i.q;
        end
    end

    // ------------------------------------------------------------------
    // Stage 3, clamp, sign restore and dequantize
    // ------------------------------------------------------------------
    always_comb begin
        level_mag  = (s2_level_q > 17'(`QB_MAX_LEVEL)) ? 11'(`QB_MAX_LEVEL) : s2_level_q[10:0];
        level_sgn  = s2_sign_q ? -coeff_t'(level_mag) : coeff_t'(level_mag);
        recon_full = level_sgn * $signed({16'd0, s2_q_q});
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= s2_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid_q) begin
            res_o.idx   <= s2_idx_q;
            res_o.level <= s2_pass_q ? level_sgn : '0;
            // Wraps to 16 bits like the software int16 store
            res_o.recon <= s2_pass_q ? coeff_t'(recon_full) : '0;
        end
    end

endmodule

/* verilog/matrix_expander.sv */
/* Matrix entry expander
   Derives iq, bias, zthresh and sharpen from one q write, two serial divisions */
`timescale 1ns/1ps
`include "vp8_quant_defs.svh"

module matrix_expander
    import vp8_quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_we_i,
    input  mat_type_t  cfg_type_i,
    input  mat_idx_t   cfg_idx_i,
    input  qstep_t     cfg_q_i,
    output logic       cfg_busy_o,
    output logic       wr_req_o,
    output mat_addr_t  wr_addr_o,
    output mat_entry_t wr_entry_o,
    input  logic       wr_gnt_i
);

    typedef enum logic [1:0] {idle, div_iq, div_zt, write} exp_state_t;

    localparam logic [31:0]  bias_dc_tab = `QB_BIAS_DC;
    localparam logic [31:0]  bias_ac_tab = `QB_BIAS_AC;
    localparam logic [127:0] sharpen_tab = `QB_SHARPEN;
    localparam logic [4:0]   last_step   = 5'(`QB_SHIFT - 1);

    exp_state_t  state_q;
    logic [4:0]  step_q;
    mat_type_t   type_q;
    mat_idx_t    idx_q;
    qstep_t      q_q;
    qstep_t      iq_q;
    qbias_t      zthresh_q;
    logic [15:0] rem_q;
    logic [16:0] dvd_q;
    qstep_t      dvs_q;
    logic [16:0] rem_sh;
    logic        q_bit;
    logic [15:0] rem_nxt;
    logic [16:0] quo_nxt;
    logic [7:0]  bias_byte;
    qbias_t      bias;
    logic [7:0]  sharpen_w;
    logic [23:0] sharpen_prod;
    qstep_t      sharpen;
    logic [16:0] zt_dividend;

    // ------------------------------------------------------------------
    // Restoring divider step, quotient bits shift into dvd_q
    // ------------------------------------------------------------------
    always_comb begin
        rem_sh  = {rem_q, dvd_q[16]};
        q_bit   = rem_sh >= {1'b0, dvs_q};
        rem_nxt = q_bit ? 16'(rem_sh - {1'b0, dvs_q}) : rem_sh[15:0];
        quo_nxt = {dvd_q[15:0], q_bit};
    end

    // DC bias only at position 0
    assign bias_byte = (idx_q == '0) ? bias_dc_tab[{type_q, 3'b000} +: 8]
                                     : bias_ac_tab[{type_q, 3'b000} +: 8];
    assign bias        = qbias_t'(bias_byte) << `QB_BIAS_SHIFT;
    assign zt_dividend = 17'((1 << `QB_SHIFT) - 1) - bias[16:0];

    // Sharpening applies to luma AC only
    assign sharpen_w    = sharpen_tab[{idx_q, 3'b000} +: 8];
    assign sharpen_prod = sharpen_w * q_q;
    assign sharpen      = (type_q == mat_luma_ac) ? qstep_t'(sharpen_prod >> `QB_SHARPEN_SHIFT)
                                                  : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                idle: begin
                    step_q <= '0;
                    if (cfg_we_i) state_q <= div_iq;
                end
                div_iq: begin
                    step_q <= (step_q == last_step) ? '0 : step_q + 5'd1;
                    if (step_q == last_step) state_q <= div_zt;
                end
                div_zt: begin
                    step_q <= (step_q == last_step) ? '0 : step_q + 5'd1;
                    if (step_q == last_step) state_q <= write;
                end
                default: begin
                    if (wr_gnt_i) state_q <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            idle: begin
                if (cfg_we_i) begin
                    type_q <= cfg_type_i;
                    idx_q  <= cfg_idx_i;
                    q_q    <= cfg_q_i;
                    // 2^17, top bit preloaded into the remainder
                    rem_q  <= 16'd1;
                    dvd_q  <= '0;
                    dvs_q  <= cfg_q_i;
                end
            end
            div_iq: begin
                if (step_q == last_step) begin
                    iq_q  <= quo_nxt[15:0];
                    rem_q <= '0;
                    dvd_q <= zt_dividend;
                    dvs_q <= quo_nxt[15:0];
                end else begin
                    rem_q <= rem_nxt;
                    dvd_q <= quo_nxt;
                end
            end
            div_zt: begin
                if (step_q == last_step) begin
                    zthresh_q <= qbias_t'(quo_nxt);
                end else begin
                    rem_q <= rem_nxt;
                    dvd_q <= quo_nxt;
                end
            end
            default: ;
        endcase
    end

    assign cfg_busy_o = (state_q != idle);
    assign wr_req_o   = (state_q == write);
    assign wr_addr_o  = '{mtype: type_q, idx: idx_q};
    assign wr_entry_o = '{q: q_q, iq: iq_q, bias: bias, zthresh: zthresh_q, sharpen: sharpen};

endmodule

/* verilog/matrix_port_arbiter.sv */
/* Matrix store port arbiter
   Fixed priority, expander writes win over quantizer reads */
`timescale 1ns/1ps

module matrix_port_arbiter
    import vp8_quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_req_i,
    input  mat_addr_t  wr_addr_i,
    input  mat_entry_t wr_entry_i,
    input  logic       rd_req_i,
    input  mat_addr_t  rd_addr_i,
    output logic       wr_gnt_o,
    output logic       rd_gnt_o,
    output logic       rd_valid_o,
    output logic       we_o,
    output logic       re_o,
    output mat_addr_t  addr_o,
    output mat_entry_t wdata_o
);

    // A losing read stays pending at the requester
    assign wr_gnt_o = wr_req_i;
    assign rd_gnt_o = rd_req_i & ~wr_req_i;

    assign we_o    = wr_gnt_o;
    assign re_o    = rd_gnt_o;
    assign addr_o  = wr_req_i ? wr_addr_i : rd_addr_i;
    assign wdata_o = wr_entry_i;

    // Store data is current one cycle after a read grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_gnt_o;
        end
    end

endmodule

/* verilog/quant_matrix_store.sv */
/* Quantization matrix store
   Single-port memory of 48 expanded entries with a registered read */
`timescale 1ns/1ps
`include "vp8_quant_defs.svh"

module quant_matrix_store
    import vp8_quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       we_i,
    input  logic       re_i,
    input  mat_addr_t  addr_i,
    input  mat_entry_t wdata_i,
    output mat_entry_t rdata_o
);

    localparam int depth = `QB_NTYPES * `QB_NCOEF;

    mat_entry_t mem [depth];
    logic [5:0] mem_idx;

    // Bank per type, 16 entries each
    assign mem_idx = 6'(addr_i.mtype * `QB_NCOEF + addr_i.idx);

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[mem_idx] <= wdata_i;
        end
    end

    // Read data is valid the cycle after re_i
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_o <= '0;
        end else if (re_i) begin
            rdata_o <= mem[mem_idx];
        end
    end

endmodule

/* verilog/vp8_quant_defs.svh */
/* VP8 quantizer constants
   Block size, fixed-point shift, level clamp and the bias and sharpen tables */
`ifndef VP8_QUANT_DEFS_SVH
`define VP8_QUANT_DEFS_SVH

`define QB_NCOEF         16
`define QB_NTYPES        3
`define QB_SHIFT         17
`define QB_MAX_LEVEL     2047

// Bias bytes per matrix type, luma AC in the low byte
`define QB_BIAS_DC       {8'd0, 8'd110, 8'd96, 8'd96}
`define QB_BIAS_AC       {8'd0, 8'd115, 8'd108, 8'd110}
`define QB_BIAS_SHIFT    9

// Sharpen weights per raster position, position 0 in the low byte
`define QB_SHARPEN       {8'd90, 8'd90, 8'd90, 8'd90, \
                          8'd90, 8'd90, 8'd90, 8'd60, \
                          8'd90, 8'd90, 8'd60, 8'd30, \
                          8'd90, 8'd60, 8'd30, 8'd0}
`define QB_SHARPEN_SHIFT 11

`endif

/* verilog/vp8_quant_pkg.sv */
/* VP8 block quantizer shared types
   Coefficients, quantization matrix entries, store addresses and results */
package vp8_quant_pkg;

    // Signed coefficient, level or reconstruction
    typedef logic signed [15:0] coeff_t;

    // Unsigned q, iq or sharpen
    typedef logic [15:0] qstep_t;

    // Bias or zero threshold in Q17
    typedef logic [31:0] qbias_t;

    // Raster position inside the 4x4 block
    typedef logic [3:0] mat_idx_t;

    typedef enum logic [1:0] {
        mat_luma_ac = 2'd0,
        mat_luma_dc = 2'd1,
        mat_chroma  = 2'd2
    } mat_type_t;

    // Store address, type selects the 16-entry bank
    typedef struct packed {
        mat_type_t mtype;
        mat_idx_t  idx;
    } mat_addr_t;

    // One expanded matrix entry, 112 bits
    typedef struct packed {
        qstep_t q;
        qstep_t iq;
        qbias_t bias;
        qbias_t zthresh;
        qstep_t sharpen;
    } mat_entry_t;

    // Whole block, element 0 in the low bits
    typedef coeff_t [15:0] coeff_block_t;

    // Per-coefficient pipeline result
    typedef struct packed {
        mat_idx_t idx;
        coeff_t   level;
        coeff_t   recon;
    } qres_t;

endpackage

/* verilog/vp8_quant_top.sv */
/* VP8 block quantizer top level
   Matrix store shared by the expander and the quantizer through an arbiter */
`timescale 1ns/1ps

module vp8_quant_top
    import vp8_quant_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cfg_we_i,
    input  mat_type_t    cfg_type_i,
    input  mat_idx_t     cfg_idx_i,
    input  qstep_t       cfg_q_i,
    output logic         cfg_busy_o,
    input  logic         start_i,
    input  mat_type_t    blk_type_i,
    input  coeff_block_t coeffs_i,
    output coeff_block_t levels_o,
    output coeff_block_t recon_o,
    output logic         nz_o,
    output logic         done_o
);

    logic       wr_req, wr_gnt, rd_req, rd_gnt, rd_valid;
    mat_addr_t  wr_addr, rd_addr, store_addr;
    mat_entry_t wr_entry, store_wdata, store_rdata;
    logic       store_we, store_re;
    logic       res_valid;
    qres_t      res;

    matrix_expander u_expander (
        .clk, .rst_n, .cfg_we_i, .cfg_type_i, .cfg_idx_i, .cfg_q_i, .cfg_busy_o,
        .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_entry_o(wr_entry), .wr_gnt_i(wr_gnt)
    );

    matrix_port_arbiter u_arbiter (
        .clk, .rst_n,
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_entry_i(wr_entry),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr),
        .wr_gnt_o(wr_gnt), .rd_gnt_o(rd_gnt), .rd_valid_o(rd_valid),
        .we_o(store_we), .re_o(store_re), .addr_o(store_addr), .wdata_o(store_wdata)
    );

    quant_matrix_store u_store (
        .clk, .rst_n, .we_i(store_we), .re_i(store_re),
        .addr_i(store_addr), .wdata_i(store_wdata), .rdata_o(store_rdata)
    );

    block_quantizer u_quantizer (
        .clk, .rst_n, .start_i, .blk_type_i, .coeffs_i,
        .rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_gnt_i(rd_gnt),
        .rd_valid_i(rd_valid), .rdata_i(store_rdata),
        .res_valid_o(res_valid), .res_o(res)
    );

    zigzag_collector u_collector (
        .clk, .rst_n, .start_i, .res_valid_i(res_valid), .res_i(res),
        .levels_o, .recon_o, .nz_o, .done_o
    );

endmodule

/* verilog/zigzag_collector.sv */
/* Result collector
   Places levels in zigzag order and reconstructions in raster order, forms nz and done */
`timescale 1ns/1ps
`include "vp8_quant_defs.svh"

module zigzag_collector
    import vp8_quant_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_i,
    input  logic         res_valid_i,
    input  qres_t        res_i,
    output coeff_block_t levels_o,
    output coeff_block_t recon_o,
    output logic         nz_o,
    output logic         done_o
);

    localparam mat_idx_t last_cnt = mat_idx_t'(`QB_NCOEF - 1);

    mat_idx_t count_q;

    // Raster position to zigzag slot
    function automatic mat_idx_t zz_slot(input mat_idx_t raster);
        case (raster)
            4'd0:    zz_slot = 4'd0;
            4'd1:    zz_slot = 4'd1;
            4'd2:    zz_slot = 4'd5;
            4'd3:    zz_slot = 4'd6;
            4'd4:    zz_slot = 4'd2;
            4'd5:    zz_slot = 4'd4;
            4'd6:    zz_slot = 4'd7;
            4'd7:    zz_slot = 4'd12;
            4'd8:    zz_slot = 4'd3;
            4'd9:    zz_slot = 4'd8;
            4'd10:   zz_slot = 4'd11;
            4'd11:   zz_slot = 4'd13;
            4'd12:   zz_slot = 4'd9;
            4'd13:   zz_slot = 4'd10;
            4'd14:   zz_slot = 4'd14;
            default: zz_slot = 4'd15;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            nz_o    <= 1'b0;
            done_o  <= 1'b0;
        end else if (start_i) begin
            count_q <= '0;
            nz_o    <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            // Pulse once the 16th result is in
            done_o <= res_valid_i && (count_q == last_cnt);
            if (res_valid_i) begin
                count_q <= count_q + 4'd1;
                if (res_i.level != '0) nz_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            levels_o[zz_slot(res_i.idx)] <= res_i.level;
            recon_o[res_i.idx]           <= res_i.recon;
        end
    end

endmodule

/* vp8_quant_top.f */
+incdir+verilog
+incdir+bench
verilog/vp8_quant_pkg.sv
verilog/quant_matrix_store.sv
verilog/matrix_port_arbiter.sv
verilog/matrix_expander.sv
verilog/block_quantizer.sv
verilog/zigzag_collector.sv
verilog/vp8_quant_top.sv
bench/vp8_quant_tb.sv
